/* include/vpu_defines.svh */
`ifndef VPU_DEFINES_SVH
`define VPU_DEFINES_SVH

// element width in bits
`define VPU_ELEM_W   16

// elements per vector register
`define VPU_ELEMS    8

// lanes handled in one execution pass
`define VPU_LANES    4

// vector registers in the register file
`define VPU_REGS     8

// index widths
`define VPU_REG_AW   3
`define VPU_ELEM_AW  3

`endif

/* verilog/vpu_pkg.sv */
`default_nettype none

`include "vpu_defines.svh"

package vpu_pkg;

    typedef logic [`VPU_ELEM_W-1:0]                elem_t;
    typedef logic [`VPU_LANES*`VPU_ELEM_W-1:0]     half_t;
    typedef logic [`VPU_REG_AW-1:0]                reg_idx_t;
    typedef logic [`VPU_ELEM_AW-1:0]               elem_idx_t;
    // register index in the upper bits, element index below
    typedef logic [`VPU_REG_AW+`VPU_ELEM_AW-1:0]   host_addr_t;

    typedef logic [1:0]                            op_t;

    localparam op_t OP_ADD = 2'd0;
    localparam op_t OP_SUB = 2'd1;
    localparam op_t OP_MAX = 2'd2;
    // reduction, result lands in element 0 only
    localparam op_t OP_DOT = 2'd3;

    typedef enum logic [2:0] {
        S_IDLE,
        S_GETOP,
        S_EXEC_1,
        S_EXEC_2,
        S_WB
    } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/vpu_vrf.sv */
`default_nettype none

`include "vpu_defines.svh"

module vpu_vrf (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire vpu_pkg::host_addr_t   rd0_addr_i,
    output vpu_pkg::elem_t             rd0_data_o,
    input  wire vpu_pkg::host_addr_t   rd1_addr_i,
    output vpu_pkg::elem_t             rd1_data_o,
    input  wire vpu_pkg::host_addr_t   host_addr_i,
    output vpu_pkg::elem_t             host_rdata_o,
    input  wire                        we_i,
    input  wire vpu_pkg::host_addr_t   waddr_i,
    input  wire vpu_pkg::elem_t        wdata_i
);

    localparam int DEPTH = `VPU_REGS * `VPU_ELEMS;

    vpu_pkg::elem_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // two fetch ports and the host port, all asynchronous
    assign rd0_data_o   = mem[rd0_addr_i];
    assign rd1_data_o   = mem[rd1_addr_i];
    assign host_rdata_o = mem[host_addr_i];

endmodule

`default_nettype wire

/* verilog/vpu_operand_fetch.sv */
`default_nettype none

`include "vpu_defines.svh"

module vpu_operand_fetch (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start_i,
    input  wire vpu_pkg::reg_idx_t     src_i,
    input  wire                        pop_i,
    input  wire vpu_pkg::elem_t        rd_data_i,
    output vpu_pkg::host_addr_t        rd_addr_o,
    output logic                       done_o,
    output vpu_pkg::half_t             half_o
);

    vpu_pkg::elem_t     queue_q [`VPU_ELEMS];
    vpu_pkg::reg_idx_t  src_q;
    vpu_pkg::elem_idx_t wr_ptr;
    logic               busy;
    logic               done_q;
    // selects which half is at the head of the queue
    logic               rd_half;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            done_q  <= 1'b0;
            wr_ptr  <= '0;
            rd_half <= 1'b0;
        end else if (start_i) begin
            busy    <= 1'b1;
            done_q  <= 1'b0;
            wr_ptr  <= '0;
            rd_half <= 1'b0;
        end else begin
            if (busy) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (wr_ptr == vpu_pkg::elem_idx_t'(`VPU_ELEMS - 1)) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
            if (pop_i) begin
                rd_half <= ~rd_half;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            src_q <= src_i;
        end
        if (busy) begin
            queue_q[wr_ptr] <= rd_data_i;
        end
    end

    assign rd_addr_o = {src_q, wr_ptr};
    assign done_o    = done_q;

    always_comb begin
        for (int i = 0; i < `VPU_LANES; i++) begin
            half_o[i*`VPU_ELEM_W +: `VPU_ELEM_W] = queue_q[int'(rd_half) * `VPU_LANES + i];
        end
    end

endmodule

`default_nettype wire

/* verilog/vpu_exec.sv */
`default_nettype none

`include "vpu_defines.svh"

module vpu_exec (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start_i,
    input  wire vpu_pkg::op_t          op_i,
    input  wire vpu_pkg::half_t        a_i,
    input  wire vpu_pkg::half_t        b_i,
    output logic                       done_o,
    output vpu_pkg::half_t             result_o,
    output vpu_pkg::elem_t             acc_o
);

    vpu_pkg::half_t lane_res;
    vpu_pkg::elem_t prod_sum;
    vpu_pkg::half_t result_q;
    vpu_pkg::elem_t acc_q;
    logic           done_q;
    // low while the next start is pass 1
    logic           pass_q;

    always_comb begin
        vpu_pkg::elem_t a_e;
        vpu_pkg::elem_t b_e;
        vpu_pkg::elem_t prod;
        lane_res = '0;
        prod_sum = '0;
        for (int i = 0; i < `VPU_LANES; i++) begin
            a_e = a_i[i*`VPU_ELEM_W +: `VPU_ELEM_W];
            b_e = b_i[i*`VPU_ELEM_W +: `VPU_ELEM_W];
            // low half of the product is the same signed or unsigned
            prod     = a_e * b_e;
            prod_sum = prod_sum + prod;
            case (op_i)
                vpu_pkg::OP_ADD: lane_res[i*`VPU_ELEM_W +: `VPU_ELEM_W] = a_e + b_e;
                vpu_pkg::OP_SUB: lane_res[i*`VPU_ELEM_W +: `VPU_ELEM_W] = a_e - b_e;
                vpu_pkg::OP_MAX: begin
                    lane_res[i*`VPU_ELEM_W +: `VPU_ELEM_W] =
                        ($signed(a_e) > $signed(b_e)) ? a_e : b_e;
                end
                default: lane_res[i*`VPU_ELEM_W +: `VPU_ELEM_W] = prod;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
            pass_q <= 1'b0;
        end else begin
            done_q <= start_i;
            if (start_i) begin
                pass_q <= ~pass_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            result_q <= lane_res;
            acc_q    <= (pass_q ? acc_q : '0) + prod_sum;
        end
    end

    assign done_o   = done_q;
    assign result_o = result_q;
    assign acc_o    = acc_q;

endmodule

`default_nettype wire

/* verilog/vpu_writeback.sv */
`default_nettype none

`include "vpu_defines.svh"

module vpu_writeback (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        capture_i,
    input  wire                        start_i,
    input  wire vpu_pkg::op_t          op_i,
    input  wire vpu_pkg::reg_idx_t     vd_i,
    input  wire vpu_pkg::half_t        result_i,
    input  wire vpu_pkg::elem_t        acc_i,
    output logic                       we_o,
    output vpu_pkg::host_addr_t        waddr_o,
    output vpu_pkg::elem_t             wdata_o,
    output logic                       done_o
);

    vpu_pkg::elem_t     buf_q [`VPU_ELEMS];
    vpu_pkg::elem_idx_t idx;
    logic               active;
    logic               cap_half;
    logic               is_dot;
    logic               last;

    assign is_dot = (op_i == vpu_pkg::OP_DOT);
    // dot writes a single element
    assign last   = active && (is_dot || idx == vpu_pkg::elem_idx_t'(`VPU_ELEMS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            idx      <= '0;
            cap_half <= 1'b0;
        end else begin
            if (capture_i && !is_dot) begin
                cap_half <= ~cap_half;
            end
            if (start_i) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (active) begin
                idx <= idx + 1'b1;
                if (last) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture_i) begin
            if (is_dot) begin
                buf_q[0] <= acc_i;
            end else begin
                for (int i = 0; i < `VPU_LANES; i++) begin
                    buf_q[int'(cap_half) * `VPU_LANES + i] <=
                        result_i[i*`VPU_ELEM_W +: `VPU_ELEM_W];
                end
            end
        end
    end

    assign we_o    = active;
    assign waddr_o = {vd_i, idx};
    assign wdata_o = buf_q[idx];
    assign done_o  = last;

endmodule

`default_nettype wire

/* verilog/vpu_controller.sv */
`default_nettype none

module vpu_controller (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        req_valid_i,
    input  wire vpu_pkg::op_t          req_op_i,
    input  wire vpu_pkg::reg_idx_t     req_vd_i,
    input  wire vpu_pkg::reg_idx_t     req_vs1_i,
    input  wire vpu_pkg::reg_idx_t     req_vs2_i,
    input  wire                        fetch_done_a_i,
    input  wire                        fetch_done_b_i,
    input  wire                        exec_done_i,
    input  wire                        wb_done_i,
    output logic                       req_ready_o,
    output vpu_pkg::op_t               op_o,
    output vpu_pkg::reg_idx_t          vd_o,
    output vpu_pkg::reg_idx_t          vs1_o,
    output vpu_pkg::reg_idx_t          vs2_o,
    output logic                       fetch_start_o,
    output logic                       queue_pop_o,
    output logic                       exec_start_o,
    output logic                       wb_capture_o,
    output logic                       wb_start_o,
    output logic                       done_o
);

    vpu_pkg::ctrl_state_t state, state_n;

    vpu_pkg::op_t         op_q;
    vpu_pkg::reg_idx_t    vd_q;
    logic                 accept;

    assign accept = req_valid_i && (state == vpu_pkg::S_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= vpu_pkg::S_IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= req_op_i;
            vd_q  <= req_vd_i;
        end
    end

    always_comb begin
        state_n       = state;
        req_ready_o   = 1'b0;
        fetch_start_o = 1'b0;
        queue_pop_o   = 1'b0;
        exec_start_o  = 1'b0;
        wb_capture_o  = 1'b0;
        wb_start_o    = 1'b0;
        done_o        = 1'b0;

        case (state)
            vpu_pkg::S_IDLE: begin
                req_ready_o = 1'b1;
                if (accept) begin
                    fetch_start_o = 1'b1;
                    state_n       = vpu_pkg::S_GETOP;
                end
            end
            vpu_pkg::S_GETOP: begin
                if (fetch_done_a_i && fetch_done_b_i) begin
                    exec_start_o = 1'b1;
                    queue_pop_o  = 1'b1;
                    state_n      = vpu_pkg::S_EXEC_1;
                end
            end
            vpu_pkg::S_EXEC_1: begin
                if (exec_done_i) begin
                    // first half is ready in the exec result register
                    wb_capture_o = (op_q != vpu_pkg::OP_DOT);
                    exec_start_o = 1'b1;
                    queue_pop_o  = 1'b1;
                    state_n      = vpu_pkg::S_EXEC_2;
                end
            end
            vpu_pkg::S_EXEC_2: begin
                if (exec_done_i) begin
                    wb_capture_o = 1'b1;
                    wb_start_o   = 1'b1;
                    state_n      = vpu_pkg::S_WB;
                end
            end
            vpu_pkg::S_WB: begin
                if (wb_done_i) begin
                    done_o  = 1'b1;
                    state_n = vpu_pkg::S_IDLE;
                end
            end
            default: state_n = vpu_pkg::S_IDLE;
        endcase
    end

    assign op_o  = op_q;
    assign vd_o  = vd_q;
    // the fetch units latch the source indices themselves in the accept cycle
    assign vs1_o = req_vs1_i;
    assign vs2_o = req_vs2_i;

endmodule

`default_nettype wire

/* verilog/vpu_top.sv */
`default_nettype none

module vpu_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        req_valid_i,
    input  wire vpu_pkg::op_t          req_op_i,
    input  wire vpu_pkg::reg_idx_t     req_vd_i,
    input  wire vpu_pkg::reg_idx_t     req_vs1_i,
    input  wire vpu_pkg::reg_idx_t     req_vs2_i,
    input  wire                        host_we_i,
    input  wire vpu_pkg::host_addr_t   host_addr_i,
    input  wire vpu_pkg::elem_t        host_wdata_i,
    output logic                       req_ready_o,
    output logic                       done_o,
    output vpu_pkg::elem_t             host_rdata_o
);

    vpu_pkg::op_t        op;
    vpu_pkg::reg_idx_t   vd;
    vpu_pkg::reg_idx_t   vs1;
    vpu_pkg::reg_idx_t   vs2;
    logic                fetch_start;
    logic                fetch_done_a;
    logic                fetch_done_b;
    logic                queue_pop;
    logic                exec_start;
    logic                exec_done;
    logic                wb_capture;
    logic                wb_start;
    logic                wb_done;

    vpu_pkg::host_addr_t rd0_addr;
    vpu_pkg::host_addr_t rd1_addr;
    vpu_pkg::elem_t      rd0_data;
    vpu_pkg::elem_t      rd1_data;
    vpu_pkg::half_t      half_a;
    vpu_pkg::half_t      half_b;
    vpu_pkg::half_t      exec_result;
    vpu_pkg::elem_t      exec_acc;

    logic                wb_we;
    vpu_pkg::host_addr_t wb_waddr;
    vpu_pkg::elem_t      wb_wdata;
    logic                vrf_we;
    vpu_pkg::host_addr_t vrf_waddr;
    vpu_pkg::elem_t      vrf_wdata;

    vpu_controller u_controller (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid_i    (req_valid_i),
        .req_op_i       (req_op_i),
        .req_vd_i       (req_vd_i),
        .req_vs1_i      (req_vs1_i),
        .req_vs2_i      (req_vs2_i),
        .fetch_done_a_i (fetch_done_a),
        .fetch_done_b_i (fetch_done_b),
        .exec_done_i    (exec_done),
        .wb_done_i      (wb_done),
        .req_ready_o    (req_ready_o),
        .op_o           (op),
        .vd_o           (vd),
        .vs1_o          (vs1),
        .vs2_o          (vs2),
        .fetch_start_o  (fetch_start),
        .queue_pop_o    (queue_pop),
        .exec_start_o   (exec_start),
        .wb_capture_o   (wb_capture),
        .wb_start_o     (wb_start),
        .done_o         (done_o)
    );

    vpu_operand_fetch u_fetch_vs1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (fetch_start),
        .src_i     (vs1),
        .pop_i     (queue_pop),
        .rd_data_i (rd0_data),
        .rd_addr_o (rd0_addr),
        .done_o    (fetch_done_a),
        .half_o    (half_a)
    );

    vpu_operand_fetch u_fetch_vs2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (fetch_start),
        .src_i     (vs2),
        .pop_i     (queue_pop),
        .rd_data_i (rd1_data),
        .rd_addr_o (rd1_addr),
        .done_o    (fetch_done_b),
        .half_o    (half_b)
    );

    vpu_exec u_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (exec_start),
        .op_i     (op),
        .a_i      (half_a),
        .b_i      (half_b),
        .done_o   (exec_done),
        .result_o (exec_result),
        .acc_o    (exec_acc)
    );

    vpu_writeback u_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture_i (wb_capture),
        .start_i   (wb_start),
        .op_i      (op),
        .vd_i      (vd),
        .result_i  (exec_result),
        .acc_i     (exec_acc),
        .we_o      (wb_we),
        .waddr_o   (wb_waddr),
        .wdata_o   (wb_wdata),
        .done_o    (wb_done)
    );

    // host owns the write port only while idle
    assign vrf_we    = req_ready_o ? host_we_i    : wb_we;
    assign vrf_waddr = req_ready_o ? host_addr_i  : wb_waddr;
    assign vrf_wdata = req_ready_o ? host_wdata_i : wb_wdata;

    vpu_vrf u_vrf (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd0_addr_i   (rd0_addr),
        .rd0_data_o   (rd0_data),
        .rd1_addr_i   (rd1_addr),
        .rd1_data_o   (rd1_data),
        .host_addr_i  (host_addr_i),
        .host_rdata_o (host_rdata_o),
        .we_i         (vrf_we),
        .waddr_i      (vrf_waddr),
        .wdata_i      (vrf_wdata)
    );

endmodule

`default_nettype wire

/* tb/vpu_chk.sv */
`default_nettype none

module vpu_chk (
    input wire clk,
    input wire rst_n,
    input wire req_valid_i,
    input wire req_ready_i,
    input wire done_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic in_flight;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (req_valid_i && req_ready_i) begin
            in_flight <= 1'b1;
        end else if (done_i) begin
            in_flight <= 1'b0;
        end
    end

    // busy from the cycle after accept up to and including the done cycle
    busy_until_done: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight |-> !req_ready_i)
        else $error("req_ready_o went high while a request was in flight");

    single_done: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
        else $error("done_o was high on two consecutive cycles");

    done_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |-> !req_ready_i)
        else $error("done_o was high while req_ready_o was high");

endmodule

bind vpu_top vpu_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .done_i      (done_o)
);

`default_nettype wire

/* tb/vpu_tb.sv */
`default_nettype none

`include "vpu_defines.svh"

module vpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_B2B        = 12;
    localparam int NUM_REQ      = 8 + N_B2B;
    localparam int REQ_CYCLES   = 200;
    localparam int DEPTH        = `VPU_REGS * `VPU_ELEMS;
    // reset, zero sweep, load and final sweep
    localparam int SETUP_CYCLES = 16 + 3 * DEPTH + 50;
    localparam int VEC_W        = `VPU_ELEMS * `VPU_ELEM_W;

    logic                clk;
    logic                rst_n;
    logic                req_valid;
    vpu_pkg::op_t        req_op;
    vpu_pkg::reg_idx_t   req_vd;
    vpu_pkg::reg_idx_t   req_vs1;
    vpu_pkg::reg_idx_t   req_vs2;
    logic                host_we;
    vpu_pkg::host_addr_t host_addr;
    vpu_pkg::elem_t      host_wdata;
    logic                req_ready;
    logic                done;
    vpu_pkg::elem_t      host_rdata;

    vpu_pkg::host_addr_t stim_addr;
    vpu_pkg::host_addr_t cmp_addr;
    logic                cmp_busy;

    vpu_pkg::elem_t      shadow [DEPTH];
    logic [VEC_W-1:0]    exp_q [$];
    vpu_pkg::reg_idx_t   vd_q [$];
    int                  accepted_count;
    int                  done_count;
    int                  checked_count;
    integer              seed;

    // the compare process takes the host port while it reads a result
    assign host_addr = cmp_busy ? cmp_addr : stim_addr;

    vpu_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid),
        .req_op_i     (req_op),
        .req_vd_i     (req_vd),
        .req_vs1_i    (req_vs1),
        .req_vs2_i    (req_vs2),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .req_ready_o  (req_ready),
        .done_o       (done),
        .host_rdata_o (host_rdata)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // new contents of vd after the request, from the state before it
    function automatic logic [VEC_W-1:0] vpu_ref(input vpu_pkg::op_t op,
                                                 input vpu_pkg::reg_idx_t vd,
                                                 input vpu_pkg::reg_idx_t vs1,
                                                 input vpu_pkg::reg_idx_t vs2);
        logic [VEC_W-1:0]   res;
        vpu_pkg::elem_t     a;
        vpu_pkg::elem_t     b;
        vpu_pkg::elem_t     sum;
        logic [31:0]        prod;
        vpu_pkg::elem_idx_t e;
        sum = '0;
        for (int i = 0; i < `VPU_ELEMS; i++) begin
            e = vpu_pkg::elem_idx_t'(i);
            a = shadow[{vs1, e}];
            b = shadow[{vs2, e}];
            res[i*`VPU_ELEM_W +: `VPU_ELEM_W] = shadow[{vd, e}];
            prod = 32'(a) * 32'(b);
            sum  = sum + prod[15:0];
            case (op)
                vpu_pkg::OP_ADD: res[i*`VPU_ELEM_W +: `VPU_ELEM_W] = a + b;
                vpu_pkg::OP_SUB: res[i*`VPU_ELEM_W +: `VPU_ELEM_W] = a - b;
                vpu_pkg::OP_MAX: begin
                    res[i*`VPU_ELEM_W +: `VPU_ELEM_W] = ($signed(a) >= $signed(b)) ? a : b;
                end
                default: ;
            endcase
        end
        if (op == vpu_pkg::OP_DOT) begin
            res[`VPU_ELEM_W-1:0] = sum;
        end
        return res;
    endfunction

    task automatic read_expect(input vpu_pkg::host_addr_t addr, input vpu_pkg::elem_t expected);
        stim_addr = addr;
        @(negedge clk);
        check_value($sformatf("host_rdata_o[%0d]", addr), 32'(host_rdata), 32'(expected));
    endtask

    task automatic host_write(input vpu_pkg::host_addr_t addr, input vpu_pkg::elem_t data);
        host_we    = 1'b1;
        stim_addr  = addr;
        host_wdata = data;
        @(negedge clk);
        host_we    = 1'b0;
        shadow[addr] = data;
    endtask

    task automatic send_request(input vpu_pkg::op_t op, input vpu_pkg::reg_idx_t vd,
                                input vpu_pkg::reg_idx_t vs1, input vpu_pkg::reg_idx_t vs2);
        logic [VEC_W-1:0]   expected;
        vpu_pkg::elem_idx_t e;
        req_valid = 1'b1;
        req_op    = op;
        req_vd    = vd;
        req_vs1   = vs1;
        req_vs2   = vs2;
        // held until the unit is idle again
        while (!req_ready) begin
            @(negedge clk);
        end
        // each earlier request must already have given its done
        check_value("done count at accept", 32'(done_count), 32'(accepted_count));
        expected = vpu_ref(op, vd, vs1, vs2);
        for (int i = 0; i < `VPU_ELEMS; i++) begin
            e = vpu_pkg::elem_idx_t'(i);
            shadow[{vd, e}] = expected[i*`VPU_ELEM_W +: `VPU_ELEM_W];
        end
        exp_q.push_back(expected);
        vd_q.push_back(vd);
        accepted_count++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_compare_idle();
        while (checked_count != accepted_count) begin
            @(negedge clk);
        end
    endtask

    initial begin : compare_results
        logic [VEC_W-1:0]  exp_vec;
        vpu_pkg::reg_idx_t dest;
        cmp_busy      = 1'b0;
        cmp_addr      = '0;
        done_count    = 0;
        checked_count = 0;
        forever begin
            @(negedge clk);
            if (rst_n && done) begin
                done_count++;
                if (exp_q.size() == 0) begin
                    $display("done_o pulsed with no request in flight");
                    $display("FAIL: see errors above");
                    $fatal(1, "unexpected done");
                end else begin
                    exp_vec  = exp_q.pop_front();
                    dest     = vd_q.pop_front();
                    cmp_busy = 1'b1;
                    // last write lands on the next rising edge
                    for (int i = 0; i < `VPU_ELEMS; i++) begin
                        cmp_addr = {dest, vpu_pkg::elem_idx_t'(i)};
                        @(negedge clk);
                        check_value($sformatf("host_rdata_o[v%0d.e%0d]", dest, i),
                                    32'(host_rdata),
                                    32'(exp_vec[i*`VPU_ELEM_W +: `VPU_ELEM_W]));
                    end
                    cmp_busy = 1'b0;
                    checked_count++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_REQ * REQ_CYCLES + SETUP_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish in %0d cycles",
                 NUM_REQ * REQ_CYCLES + SETUP_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        logic [31:0]         rnd;
        vpu_pkg::op_t        op;
        vpu_pkg::reg_idx_t   vd;
        vpu_pkg::reg_idx_t   vs1;
        vpu_pkg::reg_idx_t   vs2;
        vpu_pkg::host_addr_t keep_addr;
        seed           = 83;
        clk            = 1'b0;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req_op         = vpu_pkg::OP_ADD;
        req_vd         = '0;
        req_vs1        = '0;
        req_vs2        = '0;
        host_we        = 1'b0;
        stim_addr      = '0;
        host_wdata     = '0;
        accepted_count = 0;
        for (int i = 0; i < DEPTH; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // idle and cleared after reset
        check_value("req_ready_o", 32'(req_ready), 32'd1);
        check_value("done_o", 32'(done), 32'd0);
        for (int i = 0; i < DEPTH; i++) begin
            read_expect(vpu_pkg::host_addr_t'(i), 16'h0000);
        end

        for (int i = 0; i < DEPTH; i++) begin
            rnd = $random(seed);
            host_write(vpu_pkg::host_addr_t'(i), rnd[15:0]);
        end

        // elementwise on separate registers
        send_request(vpu_pkg::OP_ADD, 3'd2, 3'd0, 3'd1);
        send_request(vpu_pkg::OP_SUB, 3'd3, 3'd4, 3'd5);
        send_request(vpu_pkg::OP_MAX, 3'd6, 3'd7, 3'd0);

        // dot, with a host write to an untouched element of vd while busy
        wait_compare_idle();
        keep_addr = {3'd5, 3'd3};
        send_request(vpu_pkg::OP_DOT, 3'd5, 3'd1, 3'd2);
        check_value("req_ready_o while busy", 32'(req_ready), 32'd0);
        host_we    = 1'b1;
        stim_addr  = keep_addr;
        host_wdata = ~shadow[keep_addr];
        @(negedge clk);
        host_we = 1'b0;
        wait_compare_idle();

        // destination overlaps a source
        send_request(vpu_pkg::OP_ADD, 3'd3, 3'd3, 3'd4);
        send_request(vpu_pkg::OP_MAX, 3'd4, 3'd1, 3'd4);
        send_request(vpu_pkg::OP_SUB, 3'd7, 3'd7, 3'd7);
        send_request(vpu_pkg::OP_DOT, 3'd0, 3'd0, 3'd0);

        // back to back, valid held while the previous one runs
        for (int n = 0; n < N_B2B; n++) begin
            rnd = $random(seed);
            op  = rnd[1:0];
            vd  = rnd[4:2];
            vs1 = rnd[7:5];
            vs2 = rnd[10:8];
            send_request(op, vd, vs1, vs2);
        end
        wait_compare_idle();

        for (int i = 0; i < DEPTH; i++) begin
            read_expect(vpu_pkg::host_addr_t'(i), shadow[i]);
        end
        check_value("done count", 32'(done_count), 32'(NUM_REQ));

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* vpu.f */
+incdir+include
verilog/vpu_pkg.sv
verilog/vpu_vrf.sv
verilog/vpu_operand_fetch.sv
verilog/vpu_exec.sv
verilog/vpu_writeback.sv
verilog/vpu_controller.sv
verilog/vpu_top.sv
tb/vpu_chk.sv
tb/vpu_tb.sv

/* run_vpu.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module vpu_tb -f vpu.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vvpu_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^PASS: all tests$'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
